//--- design/rd_pkg.sv
package rd_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	// memory data word
	localparam int DATA_WIDTH       = 32;
	// slot pointer, up to four frames
	localparam int PTR_WIDTH        = 2;
	// frame size in words
	localparam int FRAME_SIZE_WIDTH = 25;
	// burst index inside the 1Gb frame store
	localparam int BURST_IDX_WIDTH  = 19;
	// memory byte address
	localparam int BYTE_ADDR_WIDTH  = 30;

	// ------------------------------
	// burst and framing constants
	// ------------------------------
	// fixed 64-word read bursts
	localparam int BURST_WORDS              = 64;
	localparam logic [5:0] BURST_BL         = 6'd63;
	// plain read, no precharge
	localparam logic [2:0] CMD_READ         = 3'b001;
	// leader plus trailer words around the image
	localparam int FRAME_OVERHEAD           = 21;
	// writer may still have this many bursts queued
	localparam int WR_GUARD                 = 4;
	// heavy traffic, reader starts one slot ahead
	localparam logic [PTR_WIDTH-1:0] PTR_RESET = 1;

	// ------------------------------
	// types
	// ------------------------------
	typedef enum logic [1:0] {
		PH_IDLE = 2'd0,
		PH_REQ  = 2'd1,
		PH_CMD  = 2'd2,
		PH_RD   = 2'd3
	} rd_phase_t;

	typedef logic [PTR_WIDTH-1:0]        frame_ptr_t;
	typedef logic [BURST_IDX_WIDTH-1:0]  burst_idx_t;
	typedef logic [FRAME_SIZE_WIDTH-1:0] frame_size_t;

	// image set means data, clear means marker
	// marker payload bit 0: 1 header, 0 trailer
	typedef struct packed {
		logic                  image;
		logic [DATA_WIDTH-1:0] payload;
	} buf_word_t;

endpackage

//--- design/rd_seq_if.sv
interface rd_seq_if;

	// sequencer side
	rd_pkg::rd_phase_t  phase;
	logic               enable;
	rd_pkg::frame_ptr_t frame_depth;
	logic               grant;
	logic               cmd_fire;
	logic               mark_tail;

	// arbiter side
	logic               able;
	logic               addr_ok;
	rd_pkg::frame_ptr_t frame_ptr;

	// command generator side
	rd_pkg::burst_idx_t burst_idx;

	// data mover side
	logic               rd_pulse;
	logic               frame_done;
	logic               burst_end;

	modport seq (
		output phase, enable, frame_depth, grant, cmd_fire, mark_tail,
		input  able, addr_ok, rd_pulse, frame_done, burst_end
	);

	modport arb (
		input  enable, frame_depth, grant, burst_idx,
		output able, addr_ok, frame_ptr
	);

	modport cmd (
		input  phase, frame_depth, cmd_fire, frame_ptr,
		output burst_idx
	);

	modport mover (
		input  phase, grant, mark_tail,
		output rd_pulse, frame_done, burst_end
	);

endinterface

//--- design/rd_frame_arbiter.sv
module rd_frame_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	input  rd_pkg::frame_ptr_t   i_wr_frame_ptr,
	input  rd_pkg::burst_idx_t   i_wr_addr,
	input  logic                 i_writing,
	output rd_pkg::frame_ptr_t   o_rd_frame_ptr,
	rd_seq_if.arb                bus
);

	rd_pkg::frame_ptr_t rd_ptr;
	rd_pkg::frame_ptr_t wr_ptr_prev;
	rd_pkg::burst_idx_t wr_addr_sub;
	logic               addr_less;
	logic               writing_q;
	logic               grant_q;
	logic               fresh_frame;

	// ------------------------------
	// slot pointer
	// ------------------------------
	// parked at the reset slot while disabled or single frame
	always_ff @(posedge clk) begin
		if (reset || !bus.enable || bus.frame_depth == '0) begin
			rd_ptr <= rd_pkg::PTR_RESET;
		end else if (bus.grant) begin
			// ring wraps after the depth value
			if (rd_ptr == bus.frame_depth) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign o_rd_frame_ptr = rd_ptr;
	assign bus.frame_ptr  = rd_ptr;

	// ------------------------------
	// single frame freshness
	// ------------------------------
	// grant_q marks the rise of reading
	always_ff @(posedge clk) begin
		if (reset) begin
			writing_q <= 1'b0;
			grant_q   <= 1'b0;
		end else begin
			writing_q <= i_writing;
			grant_q   <= bus.grant;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !bus.enable || bus.frame_depth != '0) begin
			fresh_frame <= 1'b0;
		end else if (i_writing && !writing_q) begin
			// writer started a new frame
			fresh_frame <= 1'b1;
		end else if (grant_q) begin
			// frame consumed
			fresh_frame <= 1'b0;
		end
	end

	// heavy traffic rule, keep two slots between reader and writer
	assign wr_ptr_prev = i_wr_frame_ptr - 1'b1;
	assign bus.able    = (bus.frame_depth == '0) ? fresh_frame :
		(rd_ptr != i_wr_frame_ptr && rd_ptr != wr_ptr_prev);

	// ------------------------------
	// writer tracking
	// ------------------------------
	// saturated write address minus guard
	always_ff @(posedge clk) begin
		if (i_wr_addr < rd_pkg::BURST_IDX_WIDTH'(rd_pkg::WR_GUARD)) begin
			wr_addr_sub <= '0;
		end else begin
			wr_addr_sub <= i_wr_addr - rd_pkg::BURST_IDX_WIDTH'(rd_pkg::WR_GUARD);
		end
	end

	always_ff @(posedge clk) begin
		addr_less <= (bus.burst_idx < wr_addr_sub);
	end

	// only throttled when sharing a slot with an active writer
	assign bus.addr_ok = (rd_ptr != i_wr_frame_ptr) || !i_writing || addr_less;

endmodule

//--- design/rd_sequencer.sv
module rd_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  rd_pkg::frame_ptr_t   i_frame_depth,
	input  logic                 i_start_full_frame,
	input  logic                 i_start_quick,
	input  logic                 i_calib_done,
	input  logic                 i_rd_ack,
	input  logic                 i_buf_full,
	input  logic                 i_p3_cmd_full,
	output logic                 o_rd_req,
	output logic                 o_reading,
	output logic                 o_reset_back_buf,
	rd_seq_if.seq                bus
);

	rd_pkg::rd_phase_t phase;
	rd_pkg::rd_phase_t phase_next;
	logic [1:0]        calib_sync;
	logic              full_frame_q;
	logic              enable_q;

	// ------------------------------
	// input capture
	// ------------------------------
	// calib flag comes from the memory controller clock
	always_ff @(posedge clk) begin
		if (reset) begin
			calib_sync <= 2'b00;
		end else begin
			calib_sync <= {calib_sync[0], i_calib_done};
		end
	end

	// depth and full-frame enable only change between frames
	always_ff @(posedge clk) begin
		if (reset) begin
			bus.frame_depth <= '0;
			full_frame_q    <= 1'b0;
		end else if (phase == rd_pkg::PH_IDLE) begin
			bus.frame_depth <= i_frame_depth;
			full_frame_q    <= i_start_full_frame;
		end
	end

	// quick enable stops mid-frame
	assign bus.enable = full_frame_q & i_start_quick;

	always_ff @(posedge clk) begin
		if (reset) begin
			enable_q <= 1'b0;
		end else begin
			enable_q <= bus.enable;
		end
	end

	// flush back buffer on each enable rise
	assign o_reset_back_buf = reset | (bus.enable & ~enable_q);

	// ------------------------------
	// phase decisions
	// ------------------------------
	assign bus.grant     = (phase == rd_pkg::PH_REQ) && bus.enable && i_rd_ack && bus.able;
	assign bus.mark_tail = (phase == rd_pkg::PH_CMD) && (!bus.enable || bus.frame_done);
	assign bus.cmd_fire  = (phase == rd_pkg::PH_CMD) && bus.enable && !bus.frame_done &&
		bus.addr_ok && !i_p3_cmd_full;

	always_comb begin
		phase_next = phase;
		case (phase)
			rd_pkg::PH_IDLE: begin
				// able checked here too, avoids idle/req ping-pong
				if (bus.enable && !i_buf_full && calib_sync[1] && bus.able) begin
					phase_next = rd_pkg::PH_REQ;
				end
			end
			rd_pkg::PH_REQ: begin
				if (!bus.enable) begin
					phase_next = rd_pkg::PH_IDLE;
				end else if (i_rd_ack) begin
					// ack resolves the request either way
					phase_next = bus.able ? rd_pkg::PH_CMD : rd_pkg::PH_IDLE;
				end
			end
			rd_pkg::PH_CMD: begin
				if (bus.mark_tail) begin
					phase_next = rd_pkg::PH_IDLE;
				end else if (bus.cmd_fire) begin
					phase_next = rd_pkg::PH_RD;
				end
			end
			rd_pkg::PH_RD: begin
				// whole burst drained
				if (bus.burst_end) begin
					phase_next = rd_pkg::PH_CMD;
				end
			end
			default: begin
				phase_next = rd_pkg::PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= rd_pkg::PH_IDLE;
		end else begin
			phase <= phase_next;
		end
	end

	assign bus.phase = phase;

	// ------------------------------
	// judge handshake
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			o_rd_req  <= 1'b0;
			o_reading <= 1'b0;
		end else begin
			o_rd_req <= (phase == rd_pkg::PH_REQ) && !i_rd_ack;
			if (phase == rd_pkg::PH_IDLE) begin
				o_reading <= 1'b0;
			end else if (bus.grant) begin
				o_reading <= 1'b1;
			end
		end
	end

endmodule

//--- design/rd_cmd_gen.sv
module rd_cmd_gen (
	input  logic                                clk,
	output logic                                o_p3_cmd_en,
	output logic [2:0]                          o_p3_cmd_instr,
	output logic [5:0]                          o_p3_cmd_bl,
	output logic [rd_pkg::BYTE_ADDR_WIDTH-1:0]  o_p3_cmd_byte_addr,
	rd_seq_if.cmd                               bus
);

	rd_pkg::burst_idx_t burst_idx;
	rd_pkg::burst_idx_t addr_field;
	logic               cmd_en_q;

	// ------------------------------
	// command strobe
	// ------------------------------
	// one cycle per fired burst
	always_ff @(posedge clk) begin
		cmd_en_q <= bus.cmd_fire;
	end

	assign o_p3_cmd_en = cmd_en_q;

	// fixed opcode and burst length
	assign o_p3_cmd_instr = rd_pkg::CMD_READ;
	assign o_p3_cmd_bl    = rd_pkg::BURST_BL;

	// ------------------------------
	// burst index
	// ------------------------------
	// address holds during the strobe, steps after it
	always_ff @(posedge clk) begin
		if (bus.phase == rd_pkg::PH_IDLE) begin
			burst_idx <= '0;
		end else if (cmd_en_q) begin
			burst_idx <= burst_idx + 1'b1;
		end
	end

	assign bus.burst_idx = burst_idx;

	// ------------------------------
	// byte address map
	// ------------------------------
	// slot bits on top, burst index below
	always_comb begin
		case (bus.frame_depth)
			2'd0: begin
				// single frame uses the whole store
				addr_field = burst_idx;
			end
			2'd1: begin
				// two frames
				addr_field = {bus.frame_ptr[0], burst_idx[17:0]};
			end
			default: begin
				// three or four frames
				addr_field = {bus.frame_ptr[1:0], burst_idx[16:0]};
			end
		endcase
	end

	// 256 bytes per burst, low byte always zero
	assign o_p3_cmd_byte_addr = {3'b000, addr_field, 8'h00};

endmodule

//--- design/rd_data_mover.sv
module rd_data_mover (
	input  logic                            clk,
	input  logic                            i_p3_rd_empty,
	input  logic [rd_pkg::DATA_WIDTH-1:0]   i_p3_rd_data,
	input  logic                            i_buf_full,
	input  rd_pkg::frame_size_t             i_frame_size,
	output logic                            o_p3_rd_en,
	output rd_pkg::buf_word_t               o_buf_din,
	output logic                            o_buf_wr_en,
	rd_seq_if.mover                         bus
);

	logic [$clog2(rd_pkg::BURST_WORDS)-1:0] word_cnt;
	rd_pkg::frame_size_t                    size_cnt;
	logic                                   frame_done;

	// ------------------------------
	// read strobe
	// ------------------------------
	// fwft fifo, word is valid while not empty
	assign bus.rd_pulse = (bus.phase == rd_pkg::PH_RD) && !i_p3_rd_empty && !i_buf_full;
	assign o_p3_rd_en   = bus.rd_pulse;

	// words taken in the current burst
	always_ff @(posedge clk) begin
		if (bus.phase == rd_pkg::PH_IDLE) begin
			word_cnt <= '0;
		end else if (bus.rd_pulse) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// 64th strobe closes the burst
	assign bus.burst_end = bus.rd_pulse && (word_cnt == $bits(word_cnt)'(rd_pkg::BURST_WORDS - 1));

	// ------------------------------
	// frame size countdown
	// ------------------------------
	always_ff @(posedge clk) begin
		if (bus.phase == rd_pkg::PH_IDLE) begin
			// image plus leader and trailer, minus one
			size_cnt <= i_frame_size + rd_pkg::FRAME_SIZE_WIDTH'(rd_pkg::FRAME_OVERHEAD - 1);
		end else if (bus.rd_pulse) begin
			size_cnt <= size_cnt - 1'b1;
		end
	end

	// last wanted word read, rest of the burst is dropped
	always_ff @(posedge clk) begin
		if (bus.phase == rd_pkg::PH_IDLE) begin
			frame_done <= 1'b0;
		end else if (bus.rd_pulse && size_cnt == '0) begin
			frame_done <= 1'b1;
		end
	end

	assign bus.frame_done = frame_done;

	// ------------------------------
	// back buffer write
	// ------------------------------
	// excess words still drain the fifo but never get written
	always_ff @(posedge clk) begin
		o_buf_wr_en <= (bus.rd_pulse && !frame_done) || bus.grant || bus.mark_tail;
	end

	always_ff @(posedge clk) begin
		if (bus.grant) begin
			// header marker
			o_buf_din.image   <= 1'b0;
			o_buf_din.payload <= rd_pkg::DATA_WIDTH'(1);
		end else if (bus.mark_tail) begin
			// trailer marker
			o_buf_din.image   <= 1'b0;
			o_buf_din.payload <= '0;
		end else begin
			o_buf_din.image   <= 1'b1;
			o_buf_din.payload <= i_p3_rd_data;
		end
	end

endmodule

//--- design/rd_logic.sv
module rd_logic (
	input  logic                                  clk,
	input  logic                                  reset,

	// control
	input  logic [rd_pkg::PTR_WIDTH-1:0]          i_frame_depth,
	input  logic [rd_pkg::FRAME_SIZE_WIDTH-1:0]   i_frame_size,
	input  logic                                  i_start_full_frame,
	input  logic                                  i_start_quick,
	input  logic                                  i_calib_done,

	// judge
	output logic                                  o_rd_req,
	input  logic                                  i_rd_ack,
	output logic                                  o_reading,
	output logic [rd_pkg::PTR_WIDTH-1:0]          o_rd_frame_ptr,

	// writer status
	input  logic [rd_pkg::PTR_WIDTH-1:0]          i_wr_frame_ptr,
	input  logic [rd_pkg::BURST_IDX_WIDTH-1:0]    i_wr_addr,
	input  logic                                  i_writing,

	// memory command port
	output logic                                  o_p3_cmd_en,
	output logic [2:0]                            o_p3_cmd_instr,
	output logic [5:0]                            o_p3_cmd_bl,
	output logic [rd_pkg::BYTE_ADDR_WIDTH-1:0]    o_p3_cmd_byte_addr,
	input  logic                                  i_p3_cmd_full,

	// memory read fifo
	output logic                                  o_p3_rd_en,
	input  logic [rd_pkg::DATA_WIDTH-1:0]         i_p3_rd_data,
	input  logic                                  i_p3_rd_empty,

	// back buffer
	output logic                                  o_reset_back_buf,
	output logic [rd_pkg::DATA_WIDTH:0]           o_buf_din,
	output logic                                  o_buf_wr_en,
	input  logic                                  i_buf_full
);

	rd_seq_if seq_if ();

	// phase machine and judge handshake
	rd_sequencer u_sequencer (
		.clk                (clk),
		.reset              (reset),
		.i_frame_depth      (i_frame_depth),
		.i_start_full_frame (i_start_full_frame),
		.i_start_quick      (i_start_quick),
		.i_calib_done       (i_calib_done),
		.i_rd_ack           (i_rd_ack),
		.i_buf_full         (i_buf_full),
		.i_p3_cmd_full      (i_p3_cmd_full),
		.o_rd_req           (o_rd_req),
		.o_reading          (o_reading),
		.o_reset_back_buf   (o_reset_back_buf),
		.bus                (seq_if)
	);

	// slot ring and writer tracking
	rd_frame_arbiter u_frame_arbiter (
		.clk            (clk),
		.reset          (reset),
		.i_wr_frame_ptr (i_wr_frame_ptr),
		.i_wr_addr      (i_wr_addr),
		.i_writing      (i_writing),
		.o_rd_frame_ptr (o_rd_frame_ptr),
		.bus            (seq_if)
	);

	// burst commands
	rd_cmd_gen u_cmd_gen (
		.clk                (clk),
		.o_p3_cmd_en        (o_p3_cmd_en),
		.o_p3_cmd_instr     (o_p3_cmd_instr),
		.o_p3_cmd_bl        (o_p3_cmd_bl),
		.o_p3_cmd_byte_addr (o_p3_cmd_byte_addr),
		.bus                (seq_if)
	);

	// read fifo to back buffer
	rd_data_mover u_data_mover (
		.clk           (clk),
		.i_p3_rd_empty (i_p3_rd_empty),
		.i_p3_rd_data  (i_p3_rd_data),
		.i_buf_full    (i_buf_full),
		.i_frame_size  (i_frame_size),
		.o_p3_rd_en    (o_p3_rd_en),
		.o_buf_din     (o_buf_din),
		.o_buf_wr_en   (o_buf_wr_en),
		.bus           (seq_if)
	);

endmodule

//--- test/tb_rd_logic.sv
module tb_rd_logic;

	localparam int NUM_SESSIONS       = 4;
	localparam int FRAMES_PER_SESSION = 6;
	localparam int NUM_FRAMES         = NUM_SESSIONS * FRAMES_PER_SESSION;
	// frame inside each session that loses its enable
	localparam int DROP_FRAME         = 3;

	logic        clk = 1'b0;
	logic        reset;
	logic [1:0]  i_frame_depth;
	logic [24:0] i_frame_size;
	logic        i_start_full_frame;
	logic        i_start_quick;
	logic        i_calib_done;
	logic        i_rd_ack;
	logic [1:0]  i_wr_frame_ptr;
	logic [18:0] i_wr_addr;
	logic        i_writing;
	logic        i_p3_cmd_full;
	logic [31:0] i_p3_rd_data;
	logic        i_p3_rd_empty;
	logic        i_buf_full;
	logic        o_rd_req;
	logic        o_reading;
	logic [1:0]  o_rd_frame_ptr;
	logic        o_p3_cmd_en;
	logic [2:0]  o_p3_cmd_instr;
	logic [5:0]  o_p3_cmd_bl;
	logic [29:0] o_p3_cmd_byte_addr;
	logic        o_p3_rd_en;
	logic        o_reset_back_buf;
	logic [32:0] o_buf_din;
	logic        o_buf_wr_en;

	// memory model state
	logic [29:0] cmdq[$];
	logic [31:0] dataq[$];
	logic        rd_take;
	int          mem_wait;
	// judge and writer
	int          judge_wait;
	int          wr_gap;
	logic        wr_restart;
	// scoreboard
	logic [31:0] rng;
	int          sizes[NUM_FRAMES];
	int          fidx;
	int          sess_frames;
	int          cycles;
	int          limit;
	logic [1:0]  m_ptr;
	logic [1:0]  frame_slot;
	logic        m_fresh;
	logic        m_wq;
	logic        m_gq;
	logic        active;
	logic        dropped;
	logic        no_cmd;
	int          word_n;
	int          cmd_idx;
	int          drop_cnt;
	int          requick_cnt;
	logic        prev_quick;
	logic        ctl_quick;
	logic [1:0]  ctl_depth;
	logic [1:0]  depths[NUM_SESSIONS];

	rd_logic uut (.*);

	always #4 clk = ~clk;

	// xorshift32
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// byte address of a burst with slot bits above the burst index
	function automatic logic [29:0] burst_addr(input logic [1:0] slot, input logic [1:0] depth,
		input int idx);
		logic [29:0] a;
		if (depth == 2'd0) begin
			a = 30'(idx) << 8;
		end else if (depth == 2'd1) begin
			a = (30'(slot[0]) << 26) | (30'(idx & 32'h3ffff) << 8);
		end else begin
			a = (30'(slot) << 25) | (30'(idx & 32'h1ffff) << 8);
		end
		return a;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ------------------------------
	// one clock of all models
	// ------------------------------
	task automatic run_cycle();
		logic        allowed;
		logic        grant_now;
		logic        tail_now;
		logic [29:0] a;
		logic [31:0] r;
		@(negedge clk);
		cycles++;
		if (cycles > limit) begin
			$display("timeout: frames stopped completing after %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
		// word taken at the last rising edge
		if (rd_take) begin
			check(64'(dataq.size() > 0), 64'(1), "read strobe on an empty read fifo");
			void'(dataq.pop_front());
		end
		// command port
		if (o_p3_cmd_en) begin
			check(64'(no_cmd), 64'(0), "command after enable drop");
			check(64'(active), 64'(1), "command outside a frame");
			check(64'(i_p3_cmd_full), 64'(0), "command while port full");
			check(64'(o_p3_cmd_instr), 64'(3'b001), "command opcode");
			check(64'(o_p3_cmd_bl), 64'(6'd63), "burst length code");
			a = burst_addr(frame_slot, i_frame_depth, cmd_idx);
			check(64'(o_p3_cmd_byte_addr), 64'(a), "command byte address");
			// writer guard when sharing a slot
			if (i_writing && i_wr_frame_ptr == m_ptr) begin
				check(64'(cmd_idx + 4 < int'(i_wr_addr)), 64'(1), "burst too close to writer");
			end
			cmdq.push_back(o_p3_cmd_byte_addr);
			cmd_idx++;
		end
		// grant from ack driven last falling edge
		if (i_frame_depth == 2'd0) begin
			allowed = m_fresh;
		end else begin
			allowed = (m_ptr != i_wr_frame_ptr) && (m_ptr != i_wr_frame_ptr - 2'd1);
		end
		grant_now = i_rd_ack && i_start_quick && allowed;
		check(64'(o_buf_wr_en && o_buf_din == 33'h1), 64'(grant_now), "header versus grant");
		// slot ring and fresh frame flag
		if (!i_start_quick || i_frame_depth == 2'd0) begin
			m_ptr = 2'd1;
		end else if (grant_now) begin
			m_ptr = (m_ptr == i_frame_depth) ? 2'd0 : m_ptr + 2'd1;
		end
		if (!i_start_quick || i_frame_depth != 2'd0) begin
			m_fresh = 1'b0;
		end else if (i_writing && !m_wq) begin
			m_fresh = 1'b1;
		end else if (m_gq) begin
			m_fresh = 1'b0;
		end
		m_wq = i_writing;
		m_gq = grant_now;
		check(64'(o_rd_frame_ptr), 64'(m_ptr), "read slot pointer");
		// ------------------------------
		// back buffer stream
		// ------------------------------
		tail_now = 1'b0;
		if (grant_now) begin
			active     = 1'b1;
			dropped    = 1'b0;
			word_n     = 0;
			cmd_idx    = 0;
			frame_slot = m_ptr;
			drop_cnt   = (sess_frames == DROP_FRAME) ? 20 + int'(next_rand() % 60) : -1;
		end else if (o_buf_wr_en) begin
			check(64'(active), 64'(1), "back buffer write outside a frame");
			if (o_buf_din[32]) begin
				a = burst_addr(frame_slot, i_frame_depth, word_n / 64) + 30'(4 * (word_n % 64));
				check(64'(o_buf_din), 64'({1'b1, 2'b00, a}), "image data word");
				word_n++;
				check(64'(word_n <= sizes[fidx] + 21), 64'(1), "excess word reached buffer");
			end else begin
				check(64'(o_buf_din), 64'(0), "trailer marker");
				if (!dropped) begin
					check(64'(word_n), 64'(sizes[fidx] + 21), "data words per frame");
				end
				check(64'(cmdq.size() + dataq.size()), 64'(0), "memory left undrained");
				active   = 1'b0;
				tail_now = 1'b1;
				if (dropped) begin
					requick_cnt = 3;
				end
				if (i_frame_depth == 2'd0) begin
					wr_restart = 1'b1;
				end
				fidx++;
				sess_frames++;
				if (fidx < NUM_FRAMES) begin
					i_frame_size = 25'(sizes[fidx]);
				end
			end
		end
		// reading holds from the header through the trailer cycle
		check(64'(o_reading), 64'(active || tail_now), "reading flag");
		// enable drop mid-frame
		if (active && drop_cnt > 0) begin
			drop_cnt--;
		end else if (active && drop_cnt == 0) begin
			ctl_quick = 1'b0;
			dropped   = 1'b1;
			no_cmd    = 1'b1;
			drop_cnt  = -1;
		end
		if (requick_cnt > 0) begin
			requick_cnt--;
			if (requick_cnt == 0) begin
				ctl_quick = 1'b1;
				no_cmd    = 1'b0;
			end
		end
		// ------------------------------
		// drive inputs
		// ------------------------------
		prev_quick    = i_start_quick;
		i_start_quick = ctl_quick;
		i_frame_depth = ctl_depth;
		if (i_rd_ack) begin
			// acknowledge sampled at the last edge resolves the request
			check(64'(o_rd_req), 64'(0), "request held after acknowledge");
			i_rd_ack   = 1'b0;
			judge_wait = int'(next_rand() % 6);
		end else if (o_rd_req) begin
			if (judge_wait == 0) begin
				i_rd_ack = 1'b1;
			end else begin
				judge_wait--;
			end
		end
		r = next_rand();
		if (ctl_depth == 2'd0) begin
			// single frame mode keeps the writer on slot 1
			i_wr_frame_ptr = 2'd1;
			if (wr_restart) begin
				i_writing  = 1'b0;
				wr_gap     = 8 + int'(r % 8);
				wr_restart = 1'b0;
			end else if (!i_writing) begin
				if (wr_gap == 0) begin
					i_writing = 1'b1;
					i_wr_addr = '0;
				end else begin
					wr_gap--;
				end
			end else if (r[8]) begin
				i_wr_addr = i_wr_addr + 19'd1;
			end
		end else begin
			i_writing = 1'b1;
			i_wr_addr = '1;
			if (!active && r[6:4] == 3'd0) begin
				i_wr_frame_ptr = r[1:0];
			end
		end
		// memory answers one burst at a time
		if (dataq.size() == 0 && cmdq.size() > 0) begin
			if (mem_wait == 0) begin
				a = cmdq.pop_front();
				for (int k = 0; k < 64; k++) begin
					dataq.push_back({2'b00, a} + 32'(4 * k));
				end
				mem_wait = int'(r[15:13]);
			end else begin
				mem_wait--;
			end
		end
		i_p3_cmd_full = (r[17:16] == 2'd0);
		i_buf_full    = (r[19:18] == 2'd0);
		i_p3_rd_empty = (dataq.size() == 0) || (r[21:20] == 2'd0);
		i_p3_rd_data  = (dataq.size() == 0) ? 32'h0 : dataq[0];
		// combinational outputs settle after the drive
		#1;
		rd_take = o_p3_rd_en;
		if (rd_take) begin
			check(64'(i_p3_rd_empty || i_buf_full), 64'(0), "read strobe under back-pressure");
		end
		check(64'(o_reset_back_buf), 64'(i_start_quick && !prev_quick), "back buffer reset");
	endtask

	initial begin
		rng   = 32'h4ba872de;
		limit = 2000;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			sizes[i] = 40 + int'(next_rand() % 111);
			limit    = limit + (sizes[i] + 21 + 64) * 8;
		end
		depths = '{2'd2, 2'd0, 2'd3, 2'd1};
		reset = 1'b1;
		i_frame_depth = 2'd0;
		i_frame_size = 25'(sizes[0]);
		i_start_full_frame = 1'b1;
		i_start_quick = 1'b0;
		i_calib_done = 1'b1;
		i_rd_ack = 1'b0;
		i_wr_frame_ptr = 2'd0;
		i_wr_addr = '0;
		i_writing = 1'b0;
		i_p3_cmd_full = 1'b0;
		i_p3_rd_data = '0;
		i_p3_rd_empty = 1'b1;
		i_buf_full = 1'b0;
		{rd_take, m_fresh, m_wq, m_gq, active, dropped, no_cmd, wr_restart} = '0;
		{mem_wait, judge_wait, wr_gap, fidx, sess_frames, cycles, word_n, cmd_idx} = '0;
		drop_cnt = -1;
		requick_cnt = 0;
		m_ptr = 2'd1;
		frame_slot = 2'd1;
		prev_quick = 1'b0;
		ctl_quick = 1'b0;
		ctl_depth = 2'd0;
		// outputs quiet while reset is held
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			if (i > 0) begin
				check(64'({o_rd_req, o_p3_cmd_en, o_p3_rd_en, o_buf_wr_en, o_reading}),
					64'(0), "outputs during reset");
				check(64'(o_reset_back_buf), 64'(1), "back buffer reset during reset");
			end
		end
		reset = 1'b0;
		run_cycle();
		check(64'({o_rd_req, o_p3_cmd_en, o_p3_rd_en, o_buf_wr_en, o_reading}),
			64'(0), "outputs after reset");
		for (int s = 0; s < NUM_SESSIONS; s++) begin
			ctl_quick  = 1'b0;
			ctl_depth  = depths[s];
			wr_restart = (depths[s] == 2'd0);
			repeat (4) run_cycle();
			sess_frames = 0;
			ctl_quick   = 1'b1;
			while (sess_frames < FRAMES_PER_SESSION) begin
				run_cycle();
			end
		end
		ctl_quick = 1'b0;
		repeat (4) run_cycle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- rd_logic.f
design/rd_pkg.sv
design/rd_seq_if.sv
design/rd_frame_arbiter.sv
design/rd_sequencer.sv
design/rd_cmd_gen.sv
design/rd_data_mover.sv
design/rd_logic.sv
test/tb_rd_logic.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rd_logic testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rd_logic -f rd_logic.f \
	--Mdir obj_dir -o tb_rd_logic
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_rd_logic
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0
